// File: csam_settings.svh
`ifndef CSAM_SETTINGS_SVH
`define CSAM_SETTINGS_SVH

// operand and product widths.
`define CSAM_X_WIDTH 16
`define CSAM_Y_WIDTH 12
`define CSAM_Z_WIDTH 28

// register stages, sample edge to output.
`define CSAM_LATENCY 3

`endif

// File: csam_pkg.sv
`include "csam_settings.svh"

package csam_pkg;

	// **************************************************
	// operand and product words
	// **************************************************
	typedef logic signed [`CSAM_X_WIDTH-1:0] x_word_t;	// multiplicand.
	typedef logic signed [`CSAM_Y_WIDTH-1:0] y_word_t;	// multiplier.
	typedef logic signed [`CSAM_Z_WIDTH-1:0] z_word_t;

	// **************************************************
	// array internals
	// **************************************************
	// one row per multiplier bit, one column per multiplicand bit.
	typedef logic [`CSAM_X_WIDTH-1:0] pp_row_t;
	typedef pp_row_t [`CSAM_Y_WIDTH-1:0] pp_array_t;

	// carry-save rows, bit k of a carry row sits one column above sum bit k.
	typedef logic [`CSAM_X_WIDTH-1:0] cs_row_t;

	// product bits that fall out of the array directly.
	typedef logic [`CSAM_Y_WIDTH-1:0] low_bits_t;

endpackage

// File: csam_pp_gen.sv
`timescale 1ns/100ps
`include "csam_settings.svh"

module csam_pp_gen (
	input csam_pkg::x_word_t x,
	input csam_pkg::y_word_t y,
	output csam_pkg::pp_array_t pp
);

	// **************************************************
	// partial products
	// **************************************************
	// row i is weighted 2^i, column j of that row 2^(i+j).
	// a bit that pairs exactly one sign bit carries negative weight,
	// so it goes in inverted and the constant is settled downstream.

	for (genvar i = 0; i < `CSAM_Y_WIDTH; i++) begin : g_row
		for (genvar j = 0; j < `CSAM_X_WIDTH; j++) begin : g_col
			localparam bit top_col = (j == `CSAM_X_WIDTH - 1);
			localparam bit top_row = (i == `CSAM_Y_WIDTH - 1);

			if (top_col != top_row) begin : g_inv
				assign pp[i][j] = ~(x[j] & y[i]);	// nand cell.
			end else begin : g_and
				assign pp[i][j] = x[j] & y[i];
			end
		end
	end

	// x[15] & y[11] stays plain, both negative weights cancel.

endmodule

// File: csam_reduce_array.sv
`timescale 1ns/100ps
`include "csam_settings.svh"

module csam_reduce_array (
	input csam_pkg::pp_array_t pp,
	output csam_pkg::cs_row_t sum_row,
	output csam_pkg::cs_row_t carry_row,
	output csam_pkg::low_bits_t low_bits
);

	import csam_pkg::*;

	// baugh-wooley needs 2^15 + 2^11 on top of the array bits.
	// the cpa carry-in brings 2^12, the rest is ones in columns 11 to 14
	// of the first stage, bit j of a stage-1 row lying in column j+1.
	localparam cs_row_t corr_mask =
		cs_row_t'((1 << (`CSAM_X_WIDTH - 2)) - (1 << (`CSAM_Y_WIDTH - 2)));

	// stage s sum bit k lies in column s+k, carry bit k in column s+k+1.
	cs_row_t stage_sum [1:`CSAM_Y_WIDTH-1];
	cs_row_t stage_carry [1:`CSAM_Y_WIDTH-1];

	always_comb begin
		// **************************************************
		// stage 1, rows 0 and 1
		// **************************************************
		// half adders, full ones where a correction one is due.
		for (int j = 0; j < `CSAM_X_WIDTH - 1; j++) begin
			stage_sum[1][j] = pp[1][j] ^ pp[0][j+1] ^ corr_mask[j];
			stage_carry[1][j] = (pp[1][j] & pp[0][j+1]) |
				(corr_mask[j] & (pp[1][j] | pp[0][j+1]));
		end
		stage_sum[1][`CSAM_X_WIDTH-1] = pp[1][`CSAM_X_WIDTH-1];	// top bit passes.
		stage_carry[1][`CSAM_X_WIDTH-1] = 1'b0;

		// **************************************************
		// stages 2 to 11
		// **************************************************
		// each new row meets the previous sum one column down
		// and the previous carry in place.
		for (int s = 2; s < `CSAM_Y_WIDTH; s++) begin
			for (int j = 0; j < `CSAM_X_WIDTH - 1; j++) begin
				stage_sum[s][j] = pp[s][j] ^ stage_sum[s-1][j+1] ^ stage_carry[s-1][j];
				stage_carry[s][j] = (pp[s][j] & stage_sum[s-1][j+1]) |
					(pp[s][j] & stage_carry[s-1][j]) |
					(stage_sum[s-1][j+1] & stage_carry[s-1][j]);
			end
			stage_sum[s][`CSAM_X_WIDTH-1] = pp[s][`CSAM_X_WIDTH-1];
			stage_carry[s][`CSAM_X_WIDTH-1] = 1'b0;	// no carry out of the top.
		end
	end

	// **************************************************
	// outputs
	// **************************************************
	assign low_bits[0] = pp[0][0];	// column 0 has a single bit.

	for (genvar i = 1; i < `CSAM_Y_WIDTH; i++) begin : g_low
		assign low_bits[i] = stage_sum[i][0];	// settled once stage i is done.
	end

	// last stage goes to the carry-propagate adder.
	assign sum_row = stage_sum[`CSAM_Y_WIDTH-1];
	assign carry_row = stage_carry[`CSAM_Y_WIDTH-1];

endmodule

// File: csam_final_cpa.sv
`timescale 1ns/100ps
`include "csam_settings.svh"

module csam_final_cpa (
	input csam_pkg::cs_row_t sum_row,
	input csam_pkg::cs_row_t carry_row,
	output logic [`CSAM_X_WIDTH-1:0] upper
);

	// ripple chain, rc[k] enters cell k.
	logic [`CSAM_X_WIDTH-1:0] rc;

	// **************************************************
	// ripple carry-propagate adder
	// **************************************************
	// cell k covers product column 12+k.
	// sum bit 0 is already a low product bit, so the sum row
	// enters one position down against the carry row.

	assign rc[0] = 1'b1;	// part of the sign correction.

	for (genvar k = 0; k < `CSAM_X_WIDTH - 1; k++) begin : g_cell
		assign upper[k] = carry_row[k] ^ sum_row[k+1] ^ rc[k];
		assign rc[k+1] = (carry_row[k] & sum_row[k+1]) |
			(rc[k] & (carry_row[k] | sum_row[k+1]));
	end

	// inverting the top bit adds the 2^27 of the correction.
	assign upper[`CSAM_X_WIDTH-1] = ~rc[`CSAM_X_WIDTH-1];

endmodule

// File: csam_mult.sv
`timescale 1ns/100ps
`include "csam_settings.svh"

module csam_mult (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input csam_pkg::x_word_t x,
	input csam_pkg::y_word_t y,
	output logic out_valid,
	output csam_pkg::z_word_t z
);

	import csam_pkg::*;

	x_word_t x_q;
	y_word_t y_q;
	logic s1_valid;

	pp_array_t pp;
	cs_row_t sum_row;
	cs_row_t carry_row;
	low_bits_t low_bits;

	cs_row_t sum_q;
	cs_row_t carry_q;
	low_bits_t low_q;
	logic s2_valid;

	logic [`CSAM_X_WIDTH-1:0] upper;

	// **************************************************
	// stage 1, operand register
	// **************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			x_q <= x;
			y_q <= y;
		end
	end

	csam_pp_gen i_pp_gen (
		.x(x_q),
		.y(y_q),
		.pp(pp)
	);

	csam_reduce_array i_reduce_array (
		.pp(pp),
		.sum_row(sum_row),
		.carry_row(carry_row),
		.low_bits(low_bits)
	);

	// **************************************************
	// stage 2, carry-save rows
	// **************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			sum_q <= sum_row;
			carry_q <= carry_row;
			low_q <= low_bits;	// bits 0 to 11 are final already.
		end
	end

	csam_final_cpa i_final_cpa (
		.sum_row(sum_q),
		.carry_row(carry_q),
		.upper(upper)
	);

	// **************************************************
	// stage 3, product register
	// **************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			z <= '0;
		end else begin
			out_valid <= s2_valid;
			if (s2_valid) begin
				z <= {upper, low_q};	// held between strobes.
			end
		end
	end

endmodule

// File: csam_mult_chk.sv
`timescale 1ns/100ps
`include "csam_settings.svh"

module csam_mult_chk (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input csam_pkg::z_word_t z
);

	// **************************************************
	// reset
	// **************************************************
	// a reset edge leaves the strobe low.
	reset_quiet: assert property (
		@(posedge clk) !rst_n |=> !out_valid
	) else $error("out_valid high after a reset edge");

	// **************************************************
	// strobe timing
	// **************************************************
	// every accepted pair and nothing else comes out.
	strobe_delay: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid == $past(in_valid, `CSAM_LATENCY)
	) else $error("out_valid does not follow in_valid by the pipeline depth");

	// **************************************************
	// product contents
	// **************************************************
	product_known: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(z)
	) else $error("z has unknown bits while out_valid is high");	// x or z in product.

endmodule

// File: tb_csam_mult.sv
`timescale 1ns/100ps
`include "csam_settings.svh"

module tb_csam_mult;

	import csam_pkg::*;

	localparam int clk_period = 20;
	localparam int drive_delay = 2;
	localparam int random_count = 200;
	localparam int gapped_count = 16;
	localparam int timeout_factor = 4;
	localparam string pattern_file = "csam_patterns.txt";

	logic clk;
	logic rst_n;
	logic in_valid;
	x_word_t x;
	y_word_t y;
	logic out_valid;
	z_word_t z;

	integer seed;
	int timeout_cycles = 0;
	int cycle_count = 0;
	int sent_count = 0;
	int result_count = 0;
	logic checking = 1'b0;

	// pattern file contents.
	x_word_t pat_x[$];
	y_word_t pat_y[$];
	z_word_t pat_z[$];

	// pairs in flight, oldest first.
	z_word_t expected_q[$];
	int accept_q[$];	// edge that sampled the pair.

	z_word_t last_z = '0;
	z_word_t exp_z;
	int accept_edge;

	csam_mult i_csam_mult (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.x(x),
		.y(y),
		.out_valid(out_valid),
		.z(z)
	);

	bind csam_mult csam_mult_chk i_chk (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.out_valid(out_valid),
		.z(z)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	// **************************************************
	// helpers
	// **************************************************
	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input longint actual, input longint expected);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Error at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	// two's-complement product of the operands, sign-extended to 28 bits.
	function automatic z_word_t signed_product(input x_word_t a, input y_word_t b);
		z_word_t wide_a;
		z_word_t wide_b;
		wide_a = z_word_t'(a);
		wide_b = z_word_t'(b);
		return wide_a * wide_b;
	endfunction

	task automatic step_cycle();
		@(posedge clk);
		#drive_delay;
	endtask

	task automatic load_patterns();
		int fd;
		int got;
		string line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen(pattern_file, "r");
		if (fd == 0) begin
			stop_with_failure({"Could not open the pattern file ", pattern_file});
		end
		while (!$feof(fd)) begin
			line = "";
			got = $fgets(line, fd);
			if (got > 0 && $sscanf(line, "%h %h %h", a, b, c) == 3) begin	// skips comments.
				pat_x.push_back(x_word_t'(a));
				pat_y.push_back(y_word_t'(b));
				pat_z.push_back(z_word_t'(c));
			end
		end
		$fclose(fd);
		if (pat_x.size() == 0) begin
			stop_with_failure("The pattern file holds no operand pairs");
		end
	endtask

	// one strobe, then gap idle cycles with junk on the operands.
	task automatic send_pair(input x_word_t a, input y_word_t b, input z_word_t expected,
		input int gap);
		in_valid = 1'b1;
		x = a;
		y = b;
		expected_q.push_back(expected);
		accept_q.push_back(cycle_count + 1);
		sent_count++;
		step_cycle();
		in_valid = 1'b0;
		repeat (gap) begin
			x = x_word_t'($random(seed));
			y = y_word_t'($random(seed));
			step_cycle();
		end
	endtask

	// **************************************************
	// output monitor
	// **************************************************
	always @(negedge clk) begin
		if (checking) begin
			if ($isunknown(out_valid)) begin
				stop_with_failure("out_valid is unknown after reset");
			end else if (out_valid) begin
				if (expected_q.size() == 0) begin
					stop_with_failure("out_valid pulsed with no operand pair in flight");
				end else begin
					exp_z = expected_q.pop_front();
					accept_edge = accept_q.pop_front();
					check_value("z", longint'(z), longint'(exp_z));
					// sampled on edge k, visible after edge k+2.
					check_value("latency", longint'(cycle_count - accept_edge),
						longint'(`CSAM_LATENCY - 1));
					last_z = z;
					result_count++;
				end
			end else begin
				check_value("z", longint'(z), longint'(last_z));	// held, zero after reset.
			end
		end
	end

	// **************************************************
	// watchdog
	// **************************************************
	initial begin
		wait (timeout_cycles > 0);
		repeat (timeout_cycles) @(posedge clk);
		stop_with_failure($sformatf("Watchdog timeout, the run did not end within %0d cycles",
			timeout_cycles));
	end

	// **************************************************
	// stimulus
	// **************************************************
	initial begin
		int gap;
		int drain_cycles;
		x_word_t rx;
		y_word_t ry;
		rst_n = 1'b0;
		in_valid = 1'b0;
		x = '0;
		y = '0;
		seed = 30418;
		load_patterns();
		timeout_cycles = (pat_x.size() + random_count + 20) * timeout_factor;

		repeat (4) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;
		checking = 1'b1;
		repeat (2) step_cycle();

		// file pairs back to back.
		for (int i = 0; i < pat_x.size(); i++) begin
			send_pair(pat_x[i], pat_y[i], pat_z[i], 0);
		end

		// same pairs with idle cycles between strobes.
		for (int i = 0; i < gapped_count && i < pat_x.size(); i++) begin
			send_pair(pat_x[i], pat_y[i], pat_z[i], 1 + (i % 3));
		end

		for (int i = 0; i < random_count; i++) begin
			rx = x_word_t'($random(seed));
			ry = y_word_t'($random(seed));
			gap = ($random(seed) & 1) + 1;
			send_pair(rx, ry, signed_product(rx, ry), gap);
		end

		// drain the pipeline, bounded by its depth.
		drain_cycles = 0;
		while (expected_q.size() != 0 && drain_cycles < `CSAM_LATENCY + 2) begin
			step_cycle();
			drain_cycles++;
		end
		repeat (`CSAM_LATENCY + 2) step_cycle();	// no stray strobes.

		if (result_count != sent_count) begin
			stop_with_failure($sformatf("Only %0d results came out for %0d pairs sent",
				result_count, sent_count));
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

// File: csam_patterns.txt
// one operand pair per line, x (16 bit) then y (12 bit) then expected z (28 bit).
// all fields hex two's complement.
0000 000 0000000
0001 001 0000001
0001 000 0000000
0000 001 0000000
FFFF FFF 0000001
8000 800 4000000
8000 7FF C008000
7FFF 800 C000800
7FFF 7FF 3FF7801
8000 001 FFF8000
8000 FFF 0008000
0001 800 FFFF800
FFFF 800 0000800
7FFF FFF FFF8001
FFFF 7FF FFFF801
0002 003 0000006
FFFE 003 FFFFFFA
0002 FFD FFFFFFA
FFFE FFD 0000006
0010 010 0000100
0100 100 0010000
1000 400 0400000
4000 400 1000000
4000 C00 F000000
C000 400 F000000
C000 C00 1000000
0003 005 000000F
000A 00A 0000064
00FF 0FF 000FE01
FF00 100 FFF0000
0064 064 0002710
FF9C 064 FFFD8F0
FF9C F9C 0002710
03E8 3E8 00F4240
FC18 3E8 FF0BDC0
1234 001 0001234
1234 002 0002468
1234 010 0012340
1234 FFF FFFEDCC
ABCD 001 FFFABCD
ABCD 010 FFABCD0
5555 003 000FFFF
AAAB 003 FFF0001
0001 555 0000555
0001 AAA FFFFAAA
0003 555 0000FFF
0100 7FF 007FF00
0100 800 FF80000
7FFF 001 0007FFF
7FFF 002 000FFFE
8000 002 FFF0000
8000 400 E000000
8000 C00 2000000
0800 800 FC00000
F800 800 0400000
0007 009 000003F
FFF9 009 FFFFFC1
0007 FF7 FFFFFC1
FFF9 FF7 000003F
00C8 00C 0000960
2000 002 0004000
0011 011 0000121
0101 101 0010201
1001 001 0001001
1111 00F 000FFFF
000F 111 0000FFF
EEEF 00F FFF0001
000F EEF FFFF001
0400 7FF 01FFC00
FC00 7FF FE00400
4000 7FF 1FFC000
C000 7FF E004000
0005 F00 FFFFB00
0123 100 0012300
FEDD 100 FFEDD00

// File: csam_mult.f
+incdir+.
csam_pkg.sv
csam_pp_gen.sv
csam_reduce_array.sv
csam_final_cpa.sv
csam_mult.sv
csam_mult_chk.sv
tb_csam_mult.sv

// File: run_sim.sh
#!/bin/sh
# Builds the multiplier testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal -j 0 \
	--top-module tb_csam_mult \
	-f csam_mult.f

status=0
./obj_dir/Vtb_csam_mult > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
	echo "simulation reported a failure"
	exit 1
fi

if [ "$status" -ne 0 ] || ! grep -qF '*** TEST PASSED ***' sim.log; then
	echo "simulation ended without a pass"
	exit 1
fi

echo "simulation passed"
